// ==== addrgen_top.f ====
+incdir+.
vec_pkg.sv
axi_ax_pkg.sv
burst_planner.sv
addrgen_req_fe.sv
axi_req_gen.sv
cmd_queue.sv
addrgen_top.sv
tb_addrgen.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_addrgen -f addrgen_top.f -o tb_addrgen \
  && ./obj_dir/tb_addrgen > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

// ==== tb_addrgen.sv ====
// Random self-checking testbench of the address generator, built from the file list as top module
`include "addrgen_settings.svh"

module tb_addrgen import vec_pkg::*; import axi_ax_pkg::*; ();

  localparam int num_instr = 40;
  localparam longint unsigned bus_mask = (64'd1 << `AXI_BYTES_LOG) - 1;
  localparam longint unsigned page_mask = (64'd1 << `PAGE_BITS) - 1;

  logic      clk_i;
  logic      rst_ni;
  vmem_req_t req_i;
  logic      req_valid_i;
  logic      req_ready_o;
  logic      ack_o;
  logic      error_o;
  ax_req_t   ar_o;
  logic      ar_valid_o;
  logic      ar_ready_i;
  ax_req_t   aw_o;
  logic      aw_valid_o;
  logic      aw_ready_i;
  ls_cmd_t   cmd_o;
  logic      cmd_valid_o;
  logic      cmd_ready_i;

  // Expected traffic as filled by the model before the run
  ax_req_t     exp_ax_q[$];
  logic        exp_load_q[$];
  ls_cmd_t     exp_cmd_q[$];
  logic        exp_err_q[$];
  int          exp_reqs_q[$];
  vmem_req_t   instrs[num_instr];

  logic [31:0] rng_q;
  int          total_reqs = 0;
  int          cycle_limit = 0;
  int          cycles = 0;
  int          acks_seen = 0;
  int          hs_since_ack = 0;
  logic        in_flight = 1'b0;
  int          ax_errs = 0;
  int          cmd_errs = 0;
  int          ack_errs = 0;
  int          ready_errs = 0;
  int          misc_errs = 0;

  addrgen_top uut (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  task automatic add_req(input longint unsigned addr, input int beats, input logic [2:0] size,
                         input logic is_load);
    ax_req_t ax;
    ls_cmd_t cmd;
    ax.addr     = addr[`ADDR_W-1:0];
    ax.len      = 8'(beats - 1);
    ax.size     = size;
    ax.burst    = BURST_INCR;
    ax.cache    = 4'b0010;
    cmd.addr    = ax.addr;
    cmd.len     = ax.len;
    cmd.size    = size;
    cmd.is_load = is_load;
    exp_ax_q.push_back(ax);
    exp_load_q.push_back(is_load);
    exp_cmd_q.push_back(cmd);
    total_reqs++;
  endtask

  task automatic expand(input vmem_req_t r);
    longint unsigned addr;
    longint unsigned stop;
    longint unsigned limit;
    longint unsigned left;
    longint unsigned covered;
    logic            is_load;
    int              first;
    first   = total_reqs;
    is_load = (r.op == OP_VLE) || (r.op == OP_VLSE);
    if (r.op == OP_NONE) begin
      exp_err_q.push_back(1'b0);
    end else if ((r.base & ((32'd1 << r.vew) - 32'd1)) != 32'd0) begin
      exp_err_q.push_back(1'b1);
    end else begin
      exp_err_q.push_back(1'b0);
      addr = r.base;
      left = r.vl;
      if (r.op == OP_VLE || r.op == OP_VSE) begin
        while (left != 0) begin
          // Burst stops at the last needed beat or earlier at the 256-beat or page limit
          stop  = (addr + (left << r.vew) - 1) | bus_mask;
          limit = (addr & ~bus_mask) + `MAX_BEATS * (bus_mask + 1) - 1;
          if (limit < stop) begin
            stop = limit;
          end
          limit = addr | page_mask;
          if (limit < stop) begin
            stop = limit;
          end
          add_req(addr & ~bus_mask, int'((stop - (addr & ~bus_mask) + 1) >> `AXI_BYTES_LOG),
                  3'(`AXI_BYTES_LOG), is_load);
          covered = (stop - addr + 1) >> r.vew;
          left    = (left > covered) ? left - covered : 0;
          addr    = stop + 1;
        end
      end else begin
        for (int k = 0; k < int'(r.vl); k++) begin
          add_req(addr + longint'(k) * r.stride, 1, {1'b0, r.vew}, is_load);
        end
      end
    end
    exp_reqs_q.push_back(total_reqs - first);
  endtask

  task automatic make_instr(output vmem_req_t r);
    logic [31:0] sel;
    rng_q = xorshift(rng_q);
    sel   = rng_q;
    r.id  = sel[`ID_W-1:0];
    case (sel[5:3])
      3'd2, 3'd3: r.op = OP_VSE;
      3'd4:       r.op = OP_VLSE;
      3'd5:       r.op = OP_VSSE;
      3'd6:       r.op = OP_NONE;
      default:    r.op = OP_VLE;
    endcase
    r.vew = vew_e'(sel[7:6]);
    // Long unit-stride vectors reach the page and 256-beat limits
    r.vl  = (r.op inside {OP_VLSE, OP_VSSE}) ? 16'(sel[12:8]) : 16'(sel[17:8]);
    rng_q  = xorshift(rng_q);
    r.base = rng_q & 32'h7fff_ffff;
    // About one base in eight keeps its misaligned low bits
    if (sel[22:20] != 3'd0) begin
      r.base = r.base & ~((32'd1 << r.vew) - 32'd1);
    end
    rng_q    = xorshift(rng_q);
    r.stride = {18'b0, rng_q[13:0]};
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_ax(input ax_req_t got, input ax_req_t exp);
    if (got !== exp) begin
      ax_errs++;
      $display("FAILED @%0t: AX addr %h len %0d size %0d burst %0d cache %h", $time,
               got.addr, got.len, got.size, got.burst, got.cache);
      $display("  expected addr %h len %0d size %0d burst %0d cache %h",
               exp.addr, exp.len, exp.size, exp.burst, exp.cache);
    end
  endtask

  task automatic check_cmd(input ls_cmd_t got, input ls_cmd_t exp);
    if (got !== exp) begin
      cmd_errs++;
      $display("FAILED @%0t: cmd addr %h len %0d size %0d load %b, expected %h %0d %0d %b",
               $time, got.addr, got.len, got.size, got.is_load,
               exp.addr, exp.len, exp.size, exp.is_load);
    end
  endtask

  task automatic check_ack(input logic got_err, input logic exp_err);
    if (got_err !== exp_err) begin
      ack_errs++;
      $display("FAILED @%0t: ack error bit %b, expected %b", $time, got_err, exp_err);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      ready_errs++;
      $display("FAILED @%0t: req_ready_o %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic take_ax(input ax_req_t got, input logic is_load);
    if (exp_ax_q.size() == 0) begin
      misc_errs++;
      $display("An AR/AW request was issued when none was expected, at time %0t", $time);
    end else begin
      if (exp_load_q.pop_front() != is_load) begin
        misc_errs++;
        $display("FAILED @%0t: request issued on the wrong channel", $time);
      end
      check_ax(got, exp_ax_q.pop_front());
    end
    hs_since_ack++;
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk_i) begin
    int n_exp;
    if (rst_ni) begin
      // Sequencer sees ready only while no instruction is in flight
      check_ready(req_ready_o, !in_flight);
      if (error_o && !ack_o) begin
        ack_errs++;
        $display("FAILED @%0t: error raised without an ack", $time);
      end
      // Queue head must share the direction of a pending request
      if (cmd_valid_o && ((ar_valid_o && !cmd_o.is_load) || (aw_valid_o && cmd_o.is_load))) begin
        misc_errs++;
        $display("FAILED @%0t: request valid against a queue head of the other direction", $time);
      end
      if (ar_valid_o && ar_ready_i) begin
        take_ax(ar_o, 1'b1);
      end
      if (aw_valid_o && aw_ready_i) begin
        take_ax(aw_o, 1'b0);
      end
      if (cmd_valid_o && cmd_ready_i) begin
        if (exp_cmd_q.size() == 0) begin
          misc_errs++;
          $display("A queue command was popped when none was expected, at time %0t", $time);
        end else begin
          check_cmd(cmd_o, exp_cmd_q.pop_front());
        end
      end
      if (ack_o) begin
        acks_seen++;
        if (exp_err_q.size() == 0) begin
          misc_errs++;
          $display("An ack arrived with no instruction outstanding, at time %0t", $time);
        end else begin
          check_ack(error_o, exp_err_q.pop_front());
          n_exp = exp_reqs_q.pop_front();
          if (hs_since_ack != n_exp) begin
            ack_errs++;
            $display("FAILED @%0t: ack after %0d requests, expected %0d", $time,
                     hs_since_ack, n_exp);
          end
        end
        hs_since_ack = 0;
        in_flight    = 1'b0;
      end
      if (req_valid_i && req_ready_o) begin
        in_flight = 1'b1;
      end
    end
  end

  // Random back-pressure on both address channels and the queue
  always @(posedge clk_i) begin
    rng_q = xorshift(rng_q);
    ar_ready_i  <= (rng_q[9:0] % 10) < 7;
    aw_ready_i  <= (rng_q[19:10] % 10) < 7;
    cmd_ready_i <= (rng_q[29:20] % 10) < 7;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT did not finish all instructions", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    ar_ready_i  = 1'b0;
    aw_ready_i  = 1'b0;
    cmd_ready_i = 1'b0;
    rng_q       = 32'h6f66;
    for (int i = 0; i < num_instr; i++) begin
      make_instr(instrs[i]);
      expand(instrs[i]);
    end
    cycle_limit = 40 * total_reqs + 500;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < num_instr; i++) begin
      req_i       <= instrs[i];
      req_valid_i <= 1'b1;
      do begin
        @(posedge clk_i);
      end while (!req_ready_o);
    end
    req_valid_i <= 1'b0;

    while (acks_seen < num_instr || exp_cmd_q.size() != 0) begin
      @(posedge clk_i);
    end
    // A few idle cycles to catch stray traffic
    repeat (8) @(posedge clk_i);
    if (exp_ax_q.size() != 0 || exp_err_q.size() != 0) begin
      misc_errs++;
      $display("Run ended with %0d requests and %0d acks still expected",
               exp_ax_q.size(), exp_err_q.size());
    end

    $display("Errors: ax %0d, cmd %0d, ack %0d, ready %0d, other %0d",
             ax_errs, cmd_errs, ack_errs, ready_errs, misc_errs);
    if (ax_errs + cmd_errs + ack_errs + ready_errs + misc_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== addrgen_top.sv ====
// Top level of the vector address generator, from sequencer instructions to AR/AW and LSU commands
`include "addrgen_settings.svh"

module addrgen_top import vec_pkg::*; import axi_ax_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Sequencer
  input  vmem_req_t req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output logic      ack_o,
  output logic      error_o,
  // AXI read address channel
  output ax_req_t   ar_o,
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  // AXI write address channel
  output ax_req_t   aw_o,
  output logic      aw_valid_o,
  input  logic      aw_ready_i,
  // Load/store unit commands
  output ls_cmd_t   cmd_o,
  output logic      cmd_valid_o,
  input  logic      cmd_ready_i
);

  addrgen_job_t job;
  logic         job_valid;
  logic         job_done;
  logic         push;
  ls_cmd_t      push_cmd;
  logic         queue_full;
  logic         queue_empty;

  addrgen_req_fe u_fe (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .job_o      (job),
    .job_valid_o(job_valid),
    .job_done_i (job_done),
    .ack_o      (ack_o),
    .error_o    (error_o)
  );

  axi_req_gen u_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .job_i         (job),
    .job_valid_i   (job_valid),
    .job_done_o    (job_done),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .aw_o          (aw_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .push_o        (push),
    .push_cmd_o    (push_cmd),
    .full_i        (queue_full),
    .head_is_load_i(cmd_o.is_load),
    .empty_i       (queue_empty)
  );

  // Head is offered whenever the queue holds a command
  assign cmd_valid_o = !queue_empty;

  cmd_queue #(
    .depth(`QUEUE_DEPTH)
  ) u_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push),
    .cmd_i  (push_cmd),
    .full_o (queue_full),
    .empty_o(queue_empty),
    .cmd_o  (cmd_o),
    .pop_i  (cmd_valid_o && cmd_ready_i)
  );

endmodule

// ==== cmd_queue.sv ====
// Circular command queue toward the load/store units with its head always visible
module cmd_queue import axi_ax_pkg::*; #(
  parameter int unsigned depth = 4
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    push_i,
  input  ls_cmd_t cmd_i,
  output logic    full_o,
  output logic    empty_o,
  output ls_cmd_t cmd_o,
  input  logic    pop_i
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [ptr_w-1:0] last_idx  = ptr_w'(depth - 1);
  localparam logic [ptr_w:0]   depth_cnt = (ptr_w + 1)'(depth);

  ls_cmd_t          mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [ptr_w:0]   count_q;
  logic             do_push, do_pop;

  assign full_o  = (count_q == depth_cnt);
  assign empty_o = (count_q == '0);
  assign cmd_o   = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == last_idx) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == last_idx) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

endmodule

// ==== axi_req_gen.sv ====
// Request generator that turns a job into AR/AW requests and matching load/store commands
`include "addrgen_settings.svh"

module axi_req_gen import vec_pkg::*; import axi_ax_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Job from the front end
  input  addrgen_job_t job_i,
  input  logic         job_valid_i,
  output logic         job_done_o,
  // AXI address channels
  output ax_req_t      ar_o,
  output logic         ar_valid_o,
  input  logic         ar_ready_i,
  output ax_req_t      aw_o,
  output logic         aw_valid_o,
  input  logic         aw_ready_i,
  // Command queue
  output logic         push_o,
  output ls_cmd_t      push_cmd_o,
  input  logic         full_i,
  input  logic         head_is_load_i,
  input  logic         empty_i
);

  localparam int unsigned len_w = $clog2(`MAX_BEATS);

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_LOAD,
    GEN_REQ,
    GEN_NEXT
  } gen_state_e;

  gen_state_e           state_d, state_q;
  addrgen_job_t         job_d, job_q;
  logic [`ADDR_W-1:0]   plan_start;
  logic [`ADDR_W-1:0]   plan_end;
  logic [len_w:0]       plan_beats;
  logic [`VL_W-1:0]     plan_elems;
  logic [len_w:0]       beats_m1;
  ax_req_t              ax_req;
  logic                 ax_hs;
  logic                 admit_new;
  logic                 admit_cur;

  burst_planner u_planner (
    .addr_i (job_q.addr),
    .len_i  (job_q.len),
    .vew_i  (job_q.vew),
    .start_o(plan_start),
    .end_o  (plan_end),
    .beats_o(plan_beats),
    .elems_o(plan_elems)
  );

  // Queue holds one direction at a time, so a request of the other kind waits for it to drain
  assign admit_new = !full_i && (empty_i || (head_is_load_i == job_i.is_load));
  assign admit_cur = !full_i && (empty_i || (head_is_load_i == job_q.is_load));

  ////////////////////
  // Request payload
  ////////////////////

  assign beats_m1 = plan_beats - 1'b1;

  always_comb begin
    ax_req.burst = BURST_INCR;
    ax_req.cache = ax_cache_modifiable;
    if (job_q.is_burst) begin
      ax_req.addr = plan_start;
      ax_req.len  = beats_m1[len_w-1:0];
      ax_req.size = 3'(`AXI_BYTES_LOG);
    end else begin
      // Strided access, one element per request
      ax_req.addr = job_q.addr;
      ax_req.len  = '0;
      ax_req.size = {1'b0, job_q.vew};
    end
  end

  assign ar_o       = ax_req;
  assign aw_o       = ax_req;
  assign ar_valid_o = (state_q == GEN_REQ) && job_q.is_load;
  assign aw_valid_o = (state_q == GEN_REQ) && !job_q.is_load;
  assign ax_hs      = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  assign push_o     = ax_hs;
  assign push_cmd_o = '{
    addr   : ax_req.addr,
    len    : ax_req.len,
    size   : ax_req.size,
    is_load: job_q.is_load
  };

  ////////////////////
  // Generator FSM
  ////////////////////

  always_comb begin
    state_d    = state_q;
    job_d      = job_q;
    job_done_o = 1'b0;

    case (state_q)
      GEN_IDLE: begin
        if (job_valid_i) begin
          job_d   = job_i;
          state_d = admit_new ? GEN_REQ : GEN_LOAD;
        end
      end
      GEN_LOAD: begin
        // Request is ready, wait for room and matching direction in the queue
        if (admit_cur) begin
          state_d = GEN_REQ;
        end
      end
      GEN_REQ: begin
        if (ax_hs) begin
          if (job_q.is_burst) begin
            job_d.addr = plan_end + 1'b1;
            job_d.len  = (job_q.len > plan_elems) ? (job_q.len - plan_elems) : '0;
          end else begin
            job_d.addr = job_q.addr + job_q.stride;
            job_d.len  = job_q.len - 1'b1;
          end
          state_d = GEN_NEXT;
        end
      end
      GEN_NEXT: begin
        if (job_q.len == '0) begin
          job_done_o = 1'b1;
          state_d    = GEN_IDLE;
        end else begin
          state_d = admit_cur ? GEN_REQ : GEN_LOAD;
        end
      end
      default: state_d = GEN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GEN_IDLE;
      job_q   <= '0;
    end else begin
      state_q <= state_d;
      job_q   <= job_d;
    end
  end

endmodule

// ==== addrgen_req_fe.sv ====
// Front end of the address generator that accepts instructions, checks alignment and acknowledges
module addrgen_req_fe import vec_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Sequencer side
  input  vmem_req_t    req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  // Request generator side
  output addrgen_job_t job_o,
  output logic         job_valid_o,
  input  logic         job_done_i,
  // Acknowledge back to the sequencer
  output logic         ack_o,
  output logic         error_o
);

  typedef enum logic [1:0] {
    FE_IDLE,
    FE_CHECK,
    FE_BUSY
  } fe_state_e;

  fe_state_e  state_d, state_q;
  vmem_req_t  req_q;
  logic       is_mem_op;
  logic       misaligned;
  logic [3:0] ew_mask;

  // Decode and alignment check on the registered instruction
  assign is_mem_op  = req_q.op inside {OP_VLE, OP_VSE, OP_VLSE, OP_VSSE};
  assign ew_mask    = (4'd1 << req_q.vew) - 4'd1;
  assign misaligned = |(req_q.base[3:0] & ew_mask);

  assign job_o = '{
    addr    : req_q.base,
    len     : req_q.vl,
    stride  : req_q.stride,
    vew     : req_q.vew,
    is_load : req_q.op inside {OP_VLE, OP_VLSE},
    is_burst: req_q.op inside {OP_VLE, OP_VSE}
  };

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin
    state_d     = state_q;
    req_ready_o = 1'b0;
    job_valid_o = 1'b0;
    ack_o       = 1'b0;
    error_o     = 1'b0;

    case (state_q)
      FE_IDLE: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_d = FE_CHECK;
        end
      end
      FE_CHECK: begin
        if (!is_mem_op) begin
          // Not a memory access, nothing to generate
          ack_o   = 1'b1;
          state_d = FE_IDLE;
        end else if (misaligned) begin
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = FE_IDLE;
        end else if (req_q.vl == '0) begin
          // Empty vector, done without any request
          ack_o   = 1'b1;
          state_d = FE_IDLE;
        end else begin
          job_valid_o = 1'b1;
          state_d     = FE_BUSY;
        end
      end
      FE_BUSY: begin
        // Job stays valid until the generator has issued its last request
        job_valid_o = 1'b1;
        if (job_done_i) begin
          ack_o   = 1'b1;
          state_d = FE_IDLE;
        end
      end
      default: state_d = FE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

endmodule

// ==== burst_planner.sv ====
// Combinational planner that bounds one burst by vector length, 256 beats and the 4 KiB page
`include "addrgen_settings.svh"

module burst_planner import vec_pkg::*; (
  input  logic [`ADDR_W-1:0]            addr_i,
  input  logic [`VL_W-1:0]              len_i,
  input  vew_e                          vew_i,
  output logic [`ADDR_W-1:0]            start_o,
  output logic [`ADDR_W-1:0]            end_o,
  output logic [$clog2(`MAX_BEATS):0]   beats_o,
  output logic [`VL_W-1:0]              elems_o
);

  localparam int unsigned bus_bytes = `AXI_DATA_W / 8;
  localparam int unsigned beat_w    = $clog2(`MAX_BEATS) + 1;

  // Bytes covered by a full burst, minus one
  localparam logic [`ADDR_W:0] burst_span = `MAX_BEATS * bus_bytes - 1;

  // One extra bit so the ends can be compared without wrapping
  logic [`ADDR_W:0]   len_bytes;
  logic [`ADDR_W:0]   last_byte;
  logic [`ADDR_W:0]   beat_end;
  logic [`ADDR_W:0]   burst_end;
  logic [`ADDR_W:0]   page_end;
  logic [`ADDR_W:0]   min_end;
  logic [`ADDR_W-1:0] span;
  logic [`ADDR_W-1:0] covered_bytes;
  logic [`ADDR_W-1:0] covered_elems;

  always_comb begin
    start_o = {addr_i[`ADDR_W-1:`AXI_BYTES_LOG], {`AXI_BYTES_LOG{1'b0}}};

    // Last byte of the beat holding the last remaining element
    len_bytes = {{(`ADDR_W + 1 - `VL_W){1'b0}}, len_i} << vew_i;
    last_byte = {1'b0, addr_i} + len_bytes - 1'b1;
    beat_end  = {last_byte[`ADDR_W:`AXI_BYTES_LOG], {`AXI_BYTES_LOG{1'b1}}};

    burst_end = {1'b0, start_o} + burst_span;
    page_end  = {1'b0, start_o[`ADDR_W-1:`PAGE_BITS], {`PAGE_BITS{1'b1}}};

    // Smallest of the three limits
    min_end = beat_end;
    if (burst_end < min_end) begin
      min_end = burst_end;
    end
    if (page_end < min_end) begin
      min_end = page_end;
    end
    end_o = min_end[`ADDR_W-1:0];

    span    = end_o - start_o;
    beats_o = span[`AXI_BYTES_LOG +: beat_w] + beat_w'(1);

    // Elements from the element address up to the burst end
    covered_bytes = end_o - addr_i + 1'b1;
    covered_elems = covered_bytes >> vew_i;
    elems_o       = covered_elems[`VL_W-1:0];
  end

endmodule

// ==== axi_ax_pkg.sv ====
// AXI address-channel and load/store command types used by the generator, queue and testbench
`include "addrgen_settings.svh"

package axi_ax_pkg;

  // AxBURST encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } ax_burst_e;

  // AxCACHE for normal non-cacheable modifiable memory
  localparam logic [3:0] ax_cache_modifiable = 4'b0010;

  // One AR or AW beat
  typedef struct packed {
    logic [`ADDR_W-1:0]             addr;
    logic [$clog2(`MAX_BEATS)-1:0]  len;
    logic [2:0]                     size;
    ax_burst_e                      burst;
    logic [3:0]                     cache;
  } ax_req_t;

  // Command for the load/store units, one per AR/AW handshake
  typedef struct packed {
    logic [`ADDR_W-1:0]             addr;
    logic [$clog2(`MAX_BEATS)-1:0]  len;
    logic [2:0]                     size;
    logic                           is_load;
  } ls_cmd_t;

endpackage

// ==== vec_pkg.sv ====
// Vector-side types shared by the front end, the request generator and the testbench
`include "addrgen_settings.svh"

package vec_pkg;

  // Vector memory opcodes seen by the address generator
  typedef enum logic [2:0] {
    OP_VLE,
    OP_VSE,
    OP_VLSE,
    OP_VSSE,
    OP_NONE
  } mem_op_e;

  // Element width, encoded as log2 of the element bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Instruction as issued by the sequencer
  typedef struct packed {
    logic [`ID_W-1:0]   id;
    mem_op_e            op;
    logic [`ADDR_W-1:0] base;
    logic [`ADDR_W-1:0] stride;
    logic [`VL_W-1:0]   vl;
    vew_e               vew;
  } vmem_req_t;

  // Job handed from the front end to the request generator
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`VL_W-1:0]   len;
    logic [`ADDR_W-1:0] stride;
    vew_e               vew;
    logic               is_load;
    logic               is_burst;  // unit stride, sent as INCR bursts
  } addrgen_job_t;

endpackage

// ==== addrgen_settings.svh ====
// Widths, queue depth and AXI limits of the address generator, included by every file using them
`ifndef ADDRGEN_SETTINGS_SVH
`define ADDRGEN_SETTINGS_SVH

////////////////////
// Address and data
////////////////////

// Physical address width
`define ADDR_W 32

// AXI data bus width in bits and log2 of its byte count
`define AXI_DATA_W 64
`define AXI_BYTES_LOG 3

////////////////////
// Instruction fields
////////////////////

`define VL_W 16
`define ID_W 3

////////////////////
// Limits
////////////////////

// Entries in the load/store command queue
`define QUEUE_DEPTH 4

// AXI burst limits
`define MAX_BEATS 256
`define PAGE_BITS 12

`endif
